// ==== list.f ====
+incdir+rtl
rtl/eth_stream_pkg.sv
rtl/eth_hdr_pkg.sv
rtl/eth_frame_source.sv
rtl/eth_hdr_parser.sv
rtl/frame_report.sv
rtl/eth_rx_top.sv
sim/tb_eth_rx.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
TOP       := tb_eth_rx
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Simulation PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@grep -q "$(PASS_MSG)" $(LOG)

check: run
	@grep -q "$(PASS_MSG)" $(LOG) && echo "check: pass message found in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_eth_rx.sv ====
`timescale 1ns/100ps

`include "eth_params.svh"

module tb_eth_rx;

	localparam int clk_period_ns = 100;
	localparam int handshake_limit = 60;
	localparam int frame_budget = 40;
	localparam int cycles_per_frame = 30;
	localparam int watchdog_ns = frame_budget * cycles_per_frame * clk_period_ns
		+ 50 * clk_period_ns;

	// header beats of the four stored frames, big-endian, bytes 0 to 39
	localparam logic [63:0] frame_hdr [4][5] = '{
		'{64'h00112233_4455a036, 64'h9f28ae9c_08004500, 64'h0022f1d3_0000ff11,
			64'h34a2c0a8_0a03c0a8, 64'h0a014002_4002000e},
		'{64'h90e2ba5d_8dc90011, 64'h22334455_08004600, 64'h002e0000_00004011,
			64'he36ac0a8_0a03c0a8, 64'h0a013776_3776001a},
		'{64'h90e2ba5d_8dc90011, 64'h22334455_08004500, 64'h002e0000_00004011,
			64'he56ac0a8_0a03c0a8, 64'h0a013776_3776001a},
		'{64'h00112233_4455a036, 64'h9f28ae9c_08004500, 64'h0022f1d3_0000ff11,
			64'h345dc0a8_0a03c0a8, 64'h0a014002_4002000e}
	};

	logic                      eth_clk;
	logic                      sys_rst;
	logic [1:0]                gen_sel;
	logic                      gen_req;
	logic                      gen_ack;
	eth_hdr_pkg::frame_info_t  rpt_info;
	logic                      rpt_req;
	logic                      rpt_ack;
	logic [`ETH_CNT_WIDTH-1:0] frames_ok;
	logic [`ETH_CNT_WIDTH-1:0] frames_bad;
	logic [`ETH_CNT_WIDTH-1:0] drop_count;

	eth_hdr_pkg::frame_info_t  exp_q[$];
	int                        errors = 0;
	int                        start_count = 0;
	int                        report_count = 0;
	int                        drop_total = 0;
	int                        model_ok = 0;
	int                        model_bad = 0;
	logic                      req_seen;

	eth_rx_top DUT (
		.eth_clk    (eth_clk),
		.sys_rst    (sys_rst),
		.gen_sel    (gen_sel),
		.gen_req    (gen_req),
		.gen_ack    (gen_ack),
		.rpt_info   (rpt_info),
		.rpt_req    (rpt_req),
		.rpt_ack    (rpt_ack),
		.frames_ok  (frames_ok),
		.frames_bad (frames_bad),
		.drop_count (drop_count)
	);

	initial eth_clk = 1'b0;
	always #(clk_period_ns / 2) eth_clk = ~eth_clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] r;
		r = x ^ (x << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	function automatic logic [7:0] frame_byte(input int f, input int k);
		logic [63:0] w;
		w = frame_hdr[f][k / 8];
		return w[63 - 8 * (k % 8) -: 8];
	endfunction

	// header fields and verdict by fixed byte offsets
	function automatic eth_hdr_pkg::frame_info_t expected_info(input int f);
		eth_hdr_pkg::frame_info_t e;
		logic [19:0]              sum;
		logic [7:0]               vi;
		int                       k;
		e = '0;
		vi = frame_byte(f, 14);
		e.ethertype = {frame_byte(f, 12), frame_byte(f, 13)};
		e.ip_version = vi[7:4];
		e.ip_ihl = vi[3:0];
		e.ip_protocol = frame_byte(f, 23);
		e.ip_src = {frame_byte(f, 26), frame_byte(f, 27), frame_byte(f, 28), frame_byte(f, 29)};
		e.ip_dst = {frame_byte(f, 30), frame_byte(f, 31), frame_byte(f, 32), frame_byte(f, 33)};
		e.udp_src = {frame_byte(f, 34), frame_byte(f, 35)};
		e.udp_dst = {frame_byte(f, 36), frame_byte(f, 37)};
		e.udp_len = {frame_byte(f, 38), frame_byte(f, 39)};
		// ones-complement sum of the ten ip header words
		sum = '0;
		for (k = 14; k < 34; k += 2) begin
			sum = sum + {4'h0, frame_byte(f, k), frame_byte(f, k + 1)};
		end
		while (sum[19:16] != 4'h0) begin
			sum = {4'h0, sum[15:0]} + {16'h0, sum[19:16]};
		end
		if (e.ethertype != 16'h0800) begin
			e.verdict = eth_hdr_pkg::V_NOT_IPV4;
		end else if (e.ip_version != 4'd4 || e.ip_ihl != 4'd5 || e.ip_protocol != 8'd17) begin
			e.verdict = eth_hdr_pkg::V_BAD_HEADER;
		end else if (sum[15:0] != 16'hffff) begin
			e.verdict = eth_hdr_pkg::V_BAD_CSUM;
		end else if (e.ip_dst != `ETH_LOCAL_IP || e.udp_dst != `ETH_LOCAL_PORT) begin
			e.verdict = eth_hdr_pkg::V_NOT_OURS;
		end else begin
			e.verdict = eth_hdr_pkg::V_ACCEPT;
		end
		return e;
	endfunction

	task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
		end
	endtask

	task automatic compare_report();
		eth_hdr_pkg::frame_info_t e;
		report_count++;
		if (exp_q.size() == 0) begin
			errors++;
			$display("report at %0t arrived with no frame outstanding", $time);
		end else begin
			e = exp_q.pop_front();
			check_field("ethertype", 32'(rpt_info.ethertype), 32'(e.ethertype));
			check_field("ip_version", 32'(rpt_info.ip_version), 32'(e.ip_version));
			check_field("ip_ihl", 32'(rpt_info.ip_ihl), 32'(e.ip_ihl));
			check_field("ip_protocol", 32'(rpt_info.ip_protocol), 32'(e.ip_protocol));
			check_field("ip_src", rpt_info.ip_src, e.ip_src);
			check_field("ip_dst", rpt_info.ip_dst, e.ip_dst);
			check_field("udp_src", 32'(rpt_info.udp_src), 32'(e.udp_src));
			check_field("udp_dst", 32'(rpt_info.udp_dst), 32'(e.udp_dst));
			check_field("udp_len", 32'(rpt_info.udp_len), 32'(e.udp_len));
			check_field("verdict", 32'(rpt_info.verdict), 32'(e.verdict));
		end
		// only four verdicts can come out of the stored frames
		if (rpt_info.verdict == eth_hdr_pkg::V_NOT_IPV4
			|| rpt_info.verdict > eth_hdr_pkg::V_NOT_OURS) begin
			errors++;
			$display("mismatch at %0t: verdict %0d is outside the four expected ones", $time,
				rpt_info.verdict);
		end
	endtask

	// compare on every rise of rpt_req
	always @(negedge eth_clk) begin
		if (sys_rst) begin
			req_seen = 1'b0;
		end else begin
			if (rpt_req && !req_seen) begin
				compare_report();
			end
			req_seen = rpt_req;
		end
	end

	// which 0 is gen_ack, 1 is rpt_req
	task automatic wait_for_output(input int which, input logic level, input string what);
		int   n;
		logic v;
		n = 0;
		v = ~level;
		while (v !== level && n < handshake_limit) begin
			@(negedge eth_clk);
			v = (which == 0) ? gen_ack : rpt_req;
			n++;
		end
		if (v !== level) begin
			errors++;
			$display("timeout at %0t waiting for %s", $time, what);
		end
	endtask

	task automatic start_frame(input logic [1:0] sel, input bit will_drop);
		eth_hdr_pkg::frame_info_t e;
		e = expected_info(int'(sel));
		if (will_drop) begin
			drop_total++;
		end else begin
			exp_q.push_back(e);
			if (e.verdict == eth_hdr_pkg::V_ACCEPT) begin
				model_ok++;
			end else begin
				model_bad++;
			end
		end
		@(negedge eth_clk);
		gen_sel = sel;
		gen_req = 1'b1;
		start_count++;
		wait_for_output(0, 1'b1, "gen_ack to rise");
		// ack must hold while the request is still up
		repeat (3) begin
			@(negedge eth_clk);
			if (gen_ack !== 1'b1) begin
				errors++;
				$display("gen_ack dropped at %0t while gen_req was still high", $time);
			end
		end
		gen_req = 1'b0;
		wait_for_output(0, 1'b0, "gen_ack to fall");
	endtask

	task automatic ack_report(input int delay);
		wait_for_output(1, 1'b1, "rpt_req to rise");
		repeat (delay) @(negedge eth_clk);
		rpt_ack = 1'b1;
		wait_for_output(1, 1'b0, "rpt_req to fall");
		rpt_ack = 1'b0;
		@(negedge eth_clk);
	endtask

	initial begin
		logic [31:0]               seed;
		logic [1:0]                sel;
		logic [`ETH_CNT_WIDTH-1:0] drops_before;
		eth_hdr_pkg::frame_info_t  held;
		sys_rst = 1'b1;
		gen_sel = 2'd0;
		gen_req = 1'b0;
		rpt_ack = 1'b0;
		repeat (10) @(posedge eth_clk);
		@(negedge eth_clk);
		sys_rst = 1'b0;
		@(negedge eth_clk);
		if (gen_ack !== 1'b0 || rpt_req !== 1'b0 || frames_ok !== '0
			|| frames_bad !== '0 || drop_count !== '0) begin
			errors++;
			$display("mismatch at %0t: outputs or counters not idle after reset", $time);
		end

		// each stored frame on its own
		for (int f = 0; f < 4; f++) begin
			start_frame(2'(f), 1'b0);
			ack_report(0);
		end

		seed = 32'd58340;
		for (int i = 0; i < 32; i++) begin
			seed = xorshift32(seed);
			sel = seed[17:16];
			start_frame(sel, 1'b0);
			seed = xorshift32(seed);
			ack_report(int'(seed[2:0]));
		end

		// slot stays full, the second frame is lost
		drops_before = drop_count;
		held = expected_info(2);
		start_frame(2'd2, 1'b0);
		wait_for_output(1, 1'b1, "rpt_req to rise");
		start_frame(2'd1, 1'b1);
		@(negedge eth_clk);
		if (drop_count !== drops_before + 1'b1) begin
			errors++;
			$display("mismatch at %0t: drop_count %0d expected %0d", $time, drop_count,
				drops_before + 1'b1);
		end
		if (rpt_info !== held) begin
			errors++;
			$display("mismatch at %0t: rpt_info changed while the slot was full", $time);
		end
		ack_report(2);

		if (frames_ok !== `ETH_CNT_WIDTH'(model_ok)) begin
			errors++;
			$display("mismatch at %0t: frames_ok %0d expected %0d", $time, frames_ok, model_ok);
		end
		if (frames_bad !== `ETH_CNT_WIDTH'(model_bad)) begin
			errors++;
			$display("mismatch at %0t: frames_bad %0d expected %0d", $time, frames_bad,
				model_bad);
		end
		// every frame beyond the one forced drop must have reached the slot
		if (drop_count !== `ETH_CNT_WIDTH'(drop_total)) begin
			errors++;
			$display("mismatch at %0t: total drop_count %0d expected %0d", $time, drop_count,
				drop_total);
		end
		if (report_count != start_count - drop_total || exp_q.size() != 0) begin
			errors++;
			$display("mismatch at %0t: %0d reports for %0d starts and %0d drops", $time,
				report_count, start_count, drop_total);
		end

		$display("errors: %0d, frames started: %0d, reports: %0d", errors, start_count,
			report_count);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("timeout: run still going after %0d ns, stopping", watchdog_ns);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== rtl/eth_rx_top.sv ====
`timescale 1ns/100ps

`include "eth_params.svh"

module eth_rx_top (
	input  logic                       eth_clk,
	input  logic                       sys_rst,
	input  logic [1:0]                 gen_sel,
	input  logic                       gen_req,
	output logic                       gen_ack,
	output eth_hdr_pkg::frame_info_t   rpt_info,
	output logic                       rpt_req,
	input  logic                       rpt_ack,
	output logic [`ETH_CNT_WIDTH-1:0]  frames_ok,
	output logic [`ETH_CNT_WIDTH-1:0]  frames_bad,
	output logic [`ETH_CNT_WIDTH-1:0]  drop_count
);

	eth_stream_pkg::axis_beat_t rx_beat;
	eth_hdr_pkg::frame_info_t   frame_info;
	logic                       info_valid;

	// stored frame player, no back-pressure
	eth_frame_source u_source (
		.eth_clk (eth_clk),
		.sys_rst (sys_rst),
		.gen_sel (gen_sel),
		.gen_req (gen_req),
		.gen_ack (gen_ack),
		.rx_beat (rx_beat)
	);

	eth_hdr_parser u_parser (
		.eth_clk    (eth_clk),
		.sys_rst    (sys_rst),
		.rx_beat    (rx_beat),
		.frame_info (frame_info),
		.info_valid (info_valid)
	);

	frame_report u_report (
		.eth_clk    (eth_clk),
		.sys_rst    (sys_rst),
		.frame_info (frame_info),
		.info_valid (info_valid),
		.rpt_info   (rpt_info),
		.rpt_req    (rpt_req),
		.rpt_ack    (rpt_ack),
		.frames_ok  (frames_ok),
		.frames_bad (frames_bad),
		.drop_count (drop_count)
	);

endmodule

// ==== rtl/frame_report.sv ====
`timescale 1ns/100ps

`include "eth_params.svh"

module frame_report (
	input  logic                           eth_clk,
	input  logic                           sys_rst,
	input  eth_hdr_pkg::frame_info_t       frame_info,
	input  logic                           info_valid,
	output eth_hdr_pkg::frame_info_t       rpt_info,
	output logic                           rpt_req,
	input  logic                           rpt_ack,
	output logic [`ETH_CNT_WIDTH-1:0]      frames_ok,
	output logic [`ETH_CNT_WIDTH-1:0]      frames_bad,
	output logic [`ETH_CNT_WIDTH-1:0]      drop_count
);

	typedef enum logic [1:0] {
		R_EMPTY,
		R_OFFER,
		R_RELEASE
	} rpt_state_t;

	rpt_state_t state;

	// counters stick at all ones
	function automatic logic [`ETH_CNT_WIDTH-1:0] sat_inc(input logic [`ETH_CNT_WIDTH-1:0] c);
		return (&c) ? c : c + 1'b1;
	endfunction

	always_ff @(posedge eth_clk) begin
		if (sys_rst) begin
			state <= R_EMPTY;
			frames_ok <= '0;
			frames_bad <= '0;
			drop_count <= '0;
		end else begin
			case (state)
			R_EMPTY: begin
				if (info_valid) begin
					state <= R_OFFER;
					if (frame_info.verdict == eth_hdr_pkg::V_ACCEPT) begin
						frames_ok <= sat_inc(frames_ok);
					end else begin
						frames_bad <= sat_inc(frames_bad);
					end
				end
			end
			R_OFFER: begin
				if (rpt_ack) begin
					state <= R_RELEASE;
				end
			end
			// slot frees once ack is back low
			R_RELEASE: begin
				if (!rpt_ack) begin
					state <= R_EMPTY;
				end
			end
			default: state <= R_EMPTY;
			endcase
			// slot busy, this result is lost
			if (info_valid && state != R_EMPTY) begin
				drop_count <= sat_inc(drop_count);
			end
		end
	end

	always_ff @(posedge eth_clk) begin
		if (state == R_EMPTY && info_valid) begin
			rpt_info <= frame_info;
		end
	end

	assign rpt_req = (state == R_OFFER);

endmodule

// ==== rtl/eth_hdr_parser.sv ====
`timescale 1ns/100ps

`include "eth_params.svh"

module eth_hdr_parser (
	input  logic                       eth_clk,
	input  logic                       sys_rst,
	input  eth_stream_pkg::axis_beat_t rx_beat,
	output eth_hdr_pkg::frame_info_t   frame_info,
	output logic                       info_valid
);

	eth_hdr_pkg::parse_state_t state;
	eth_hdr_pkg::frame_info_t  hdr;
	eth_hdr_pkg::verdict_t     verdict;
	logic [7:0]                beat_cnt;
	logic [19:0]               csum;
	logic [17:0]               beat_sum;
	logic [16:0]               fold1;
	logic [15:0]               fold2;

	// network-order word from lanes l and l+1
	function automatic logic [15:0] lane_word(input logic [63:0] d, input int unsigned l);
		return {d[8*l +: 8], d[8*l+8 +: 8]};
	endfunction

	// ip header words in this beat, bytes 14 to 33 of the frame
	always_comb begin
		case (beat_cnt)
		8'd1: beat_sum = 18'(lane_word(rx_beat.data, 6));
		8'd2, 8'd3: begin
			beat_sum = 18'(lane_word(rx_beat.data, 0)) + 18'(lane_word(rx_beat.data, 2))
				+ 18'(lane_word(rx_beat.data, 4)) + 18'(lane_word(rx_beat.data, 6));
		end
		8'd4: beat_sum = 18'(lane_word(rx_beat.data, 0));
		default: beat_sum = '0;
		endcase
	end

	// end-around carry fold and priority verdict
	always_comb begin
		fold1 = {1'b0, csum[15:0]} + 17'(csum[19:16]);
		fold2 = fold1[15:0] + 16'(fold1[16]);
		if (hdr.ethertype != 16'h0800) begin
			verdict = eth_hdr_pkg::V_NOT_IPV4;
		end else if (state != eth_hdr_pkg::P_PAYLOAD || hdr.ip_version != 4'd4
			|| hdr.ip_ihl != 4'd5 || hdr.ip_protocol != 8'd17) begin
			verdict = eth_hdr_pkg::V_BAD_HEADER;
		end else if (fold2 != 16'hffff) begin
			verdict = eth_hdr_pkg::V_BAD_CSUM;
		end else if (hdr.ip_dst != `ETH_LOCAL_IP || hdr.udp_dst != `ETH_LOCAL_PORT) begin
			verdict = eth_hdr_pkg::V_NOT_OURS;
		end else begin
			verdict = eth_hdr_pkg::V_ACCEPT;
		end
	end

	always_ff @(posedge eth_clk) begin
		if (sys_rst) begin
			state <= eth_hdr_pkg::P_IDLE;
			beat_cnt <= '0;
			info_valid <= 1'b0;
		end else begin
			info_valid <= 1'b0;
			if (rx_beat.valid) begin
				if (beat_cnt != 8'hff) begin
					beat_cnt <= beat_cnt + 8'd1;
				end
				case (state)
				eth_hdr_pkg::P_IDLE: state <= eth_hdr_pkg::P_HDR;
				eth_hdr_pkg::P_HDR: begin
					if (beat_cnt == 8'd4) begin
						state <= eth_hdr_pkg::P_PAYLOAD;
					end
				end
				default: ;
				endcase
				// end of frame, result goes out next cycle
				if (rx_beat.last) begin
					state <= eth_hdr_pkg::P_IDLE;
					beat_cnt <= '0;
					info_valid <= 1'b1;
				end
			end
		end
	end

	// header fields and running checksum
	always_ff @(posedge eth_clk) begin
		if (rx_beat.valid) begin
			if (state == eth_hdr_pkg::P_IDLE) begin
				hdr <= '0;
				csum <= '0;
			end else begin
				csum <= csum + 20'(beat_sum);
			end
			if (state == eth_hdr_pkg::P_HDR) begin
				case (beat_cnt)
				8'd1: begin
					hdr.ethertype <= lane_word(rx_beat.data, 4);
					hdr.ip_version <= rx_beat.data[55:52];
					hdr.ip_ihl <= rx_beat.data[51:48];
				end
				8'd2: hdr.ip_protocol <= rx_beat.data[63:56];
				8'd3: begin
					hdr.ip_src <= {lane_word(rx_beat.data, 2), lane_word(rx_beat.data, 4)};
					hdr.ip_dst[31:16] <= lane_word(rx_beat.data, 6);
				end
				8'd4: begin
					hdr.ip_dst[15:0] <= lane_word(rx_beat.data, 0);
					hdr.udp_src <= lane_word(rx_beat.data, 2);
					hdr.udp_dst <= lane_word(rx_beat.data, 4);
					hdr.udp_len <= lane_word(rx_beat.data, 6);
				end
				default: ;
				endcase
			end
			if (rx_beat.last) begin
				frame_info <= hdr;
				frame_info.verdict <= verdict;
			end
		end
	end

endmodule

// ==== rtl/eth_frame_source.sv ====
`timescale 1ns/100ps

`include "eth_params.svh"

module eth_frame_source (
	input  logic                       eth_clk,
	input  logic                       sys_rst,
	input  logic [1:0]                 gen_sel,
	input  logic                       gen_req,
	output logic                       gen_ack,
	output eth_stream_pkg::axis_beat_t rx_beat
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ARM,
		S_PLAY,
		S_DONE
	} src_state_t;

	src_state_t                   state;
	logic [1:0]                   sel_q;
	logic [2:0]                   beat_idx;
	logic [`ETH_DATA_WIDTH-1:0]   be_data;
	logic [`ETH_DATA_WIDTH/8-1:0] be_keep;
	logic                         be_last;
	logic                         be_hit;

	always_ff @(posedge eth_clk) begin
		if (sys_rst) begin
			state <= S_IDLE;
			beat_idx <= '0;
		end else begin
			case (state)
			S_IDLE: begin
				if (gen_req) begin
					state <= S_ARM;
				end
			end
			S_ARM: begin
				beat_idx <= '0;
				state <= S_PLAY;
			end
			S_PLAY: begin
				beat_idx <= beat_idx + 3'd1;
				if (be_last || !be_hit) begin
					state <= S_DONE;
				end
			end
			// hold ack until the requester lets go
			S_DONE: begin
				if (!gen_req) begin
					state <= S_IDLE;
				end
			end
			default: state <= S_IDLE;
			endcase
		end
	end

	// frame choice is stable while gen_req is high
	always_ff @(posedge eth_clk) begin
		if (state == S_IDLE && gen_req) begin
			sel_q <= gen_sel;
		end
	end

	assign gen_ack = (state == S_DONE);

	// stored frames, big-endian words with msb-first keep
	always_comb begin
		case ({sel_q, beat_idx})
		5'b00_000: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h00112233_4455a036};
		5'b00_001: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h9f28ae9c_08004500};
		5'b00_010: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h0022f1d3_0000ff11};
		5'b00_011: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h34a2c0a8_0a03c0a8};
		5'b00_100: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h0a014002_4002000e};
		5'b00_101: {be_hit, be_last, be_keep, be_data} = {2'b11, 8'hff, 64'h00001107_33330000};
		// version/ihl byte 46
		5'b01_000: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h90e2ba5d_8dc90011};
		5'b01_001: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h22334455_08004600};
		5'b01_010: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h002e0000_00004011};
		5'b01_011: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'he36ac0a8_0a03c0a8};
		5'b01_100: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h0a013776_3776001a};
		5'b01_101: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h0000001a_5249c267};
		5'b01_110: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h00000001_00000003};
		5'b01_111: {be_hit, be_last, be_keep, be_data} = {2'b11, 8'hf0, 64'hc0004000_00000000};
		// checksum e56a matches the 10.3 -> 10.1 addresses
		5'b10_000: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h90e2ba5d_8dc90011};
		5'b10_001: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h22334455_08004500};
		5'b10_010: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h002e0000_00004011};
		5'b10_011: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'he56ac0a8_0a03c0a8};
		5'b10_100: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h0a013776_3776001a};
		5'b10_101: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h0000001a_5249c267};
		5'b10_110: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h00000001_00000003};
		5'b10_111: {be_hit, be_last, be_keep, be_data} = {2'b11, 8'hf0, 64'hc0004000_00000000};
		// frame 0 with a corrupted checksum low byte
		5'b11_000: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h00112233_4455a036};
		5'b11_001: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h9f28ae9c_08004500};
		5'b11_010: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h0022f1d3_0000ff11};
		5'b11_011: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h345dc0a8_0a03c0a8};
		5'b11_100: {be_hit, be_last, be_keep, be_data} = {2'b10, 8'hff, 64'h0a014002_4002000e};
		5'b11_101: {be_hit, be_last, be_keep, be_data} = {2'b11, 8'hff, 64'h00001107_33330000};
		default:   {be_hit, be_last, be_keep, be_data} = '0;
		endcase
	end

	// lane 0 carries the first byte on the wire
	always_comb begin
		rx_beat = '0;
		if (state == S_PLAY && be_hit) begin
			rx_beat.valid = 1'b1;
			rx_beat.last = be_last;
			rx_beat.keep = eth_stream_pkg::reverse8(be_keep);
			rx_beat.data = eth_stream_pkg::endian_conv64(be_data);
		end
	end

endmodule

// ==== rtl/eth_hdr_pkg.sv ====
package eth_hdr_pkg;

	// per-frame result, priority order in the parser
	typedef enum logic [2:0] {
		V_ACCEPT,
		V_NOT_IPV4,
		V_BAD_HEADER,
		V_BAD_CSUM,
		V_NOT_OURS
	} verdict_t;

	typedef enum logic [1:0] {
		P_IDLE,
		P_HDR,
		P_PAYLOAD
	} parse_state_t;

	// fields pulled from the eth, ipv4 and udp headers
	typedef struct packed {
		logic [15:0] ethertype;
		logic [3:0]  ip_version;
		logic [3:0]  ip_ihl;
		logic [7:0]  ip_protocol;
		logic [31:0] ip_src;
		logic [31:0] ip_dst;
		logic [15:0] udp_src;
		logic [15:0] udp_dst;
		logic [15:0] udp_len;
		verdict_t    verdict;
	} frame_info_t;

endpackage

// ==== rtl/eth_stream_pkg.sv ====
`include "eth_params.svh"

package eth_stream_pkg;

	// one beat of the rx byte stream, frame byte 0 sits in data[7:0]
	typedef struct packed {
		logic                           valid;
		logic                           last;
		logic [`ETH_DATA_WIDTH/8-1:0]   keep;
		logic [`ETH_DATA_WIDTH-1:0]     data;
		logic                           user;
	} axis_beat_t;

	// big-endian word to little-endian byte lanes
	function automatic logic [63:0] endian_conv64(input logic [63:0] d);
		logic [63:0] r;
		for (int i = 0; i < 8; i++) begin
			r[8*i +: 8] = d[8*(7-i) +: 8];
		end
		return r;
	endfunction

	// keep written msb-first becomes lane order
	function automatic logic [7:0] reverse8(input logic [7:0] k);
		logic [7:0] r;
		for (int i = 0; i < 8; i++) begin
			r[i] = k[7-i];
		end
		return r;
	endfunction

endpackage

// ==== rtl/eth_params.svh ====
`ifndef ETH_PARAMS_SVH
`define ETH_PARAMS_SVH

// stream data width in bits
`define ETH_DATA_WIDTH 64

// accepted destination, 192.168.10.1
`define ETH_LOCAL_IP 32'hc0a80a01

// accepted udp destination port
`define ETH_LOCAL_PORT 16'h4002

`define ETH_CNT_WIDTH 16

`endif
